/* source/xif_pkg.sv */
`default_nettype none

package xif_pkg;

  // --------------------------------------------------
  // Channel widths
  // --------------------------------------------------
  localparam int unsigned XLEN       = 32;
  localparam int unsigned ID_W       = 4;
  localparam int unsigned REG_ADDR_W = 5;

  // --------------------------------------------------
  // Core-facing channel payloads
  // --------------------------------------------------

  // Instruction offered by the core with its integer operand
  typedef struct packed {
    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] rs1;
    logic [ID_W-1:0] id;
  } issue_req_t;

  // Answer during the issue transfer
  typedef struct packed {
    logic accept;
    logic writeback;
  } issue_resp_t;

  typedef struct packed {
    logic [ID_W-1:0] id;
    logic            kill;
  } commit_t;

  // we set only when the core's integer register is written
  typedef struct packed {
    logic [ID_W-1:0]       id;
    logic [REG_ADDR_W-1:0] rd;
    logic                  we;
    logic [XLEN-1:0]       data;
  } result_t;

endpackage

`default_nettype wire

/* source/fpu_pkg.sv */
`default_nettype none

package fpu_pkg;

  // --------------------------------------------------
  // Instruction fields
  // --------------------------------------------------
  localparam logic [6:0] OPC_OP_FP  = 7'b1010011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // funct7 with the single-precision fmt bits included
  localparam logic [6:0] F7_SGNJ    = 7'b0010000;
  localparam logic [6:0] F7_CVT_S_W = 7'b1101000;
  localparam logic [6:0] F7_MV_X_W  = 7'b1110000;
  localparam logic [6:0] F7_MV_W_X  = 7'b1111000;

  localparam logic [2:0] F3_SGNJ  = 3'b000;
  localparam logic [2:0] F3_SGNJN = 3'b001;
  localparam logic [2:0] F3_SGNJX = 3'b010;
  localparam logic [2:0] F3_MV    = 3'b000;
  localparam logic [2:0] F3_CSRRW = 3'b001;

  // R-type layout, also covers the CSR address in funct7 and rs2
  typedef struct packed {
    logic [6:0]                     funct7;
    logic [xif_pkg::REG_ADDR_W-1:0] rs2;
    logic [xif_pkg::REG_ADDR_W-1:0] rs1;
    logic [2:0]                     funct3;
    logic [xif_pkg::REG_ADDR_W-1:0] rd;
    logic [6:0]                     opcode;
  } rtype_t;

  // --------------------------------------------------
  // CSRs
  // --------------------------------------------------
  localparam int unsigned              CSR_ADDR_W = 12;
  localparam logic [CSR_ADDR_W-1:0]    CSR_FFLAGS = 12'h001;
  localparam logic [CSR_ADDR_W-1:0]    CSR_FRM    = 12'h002;
  localparam logic [CSR_ADDR_W-1:0]    CSR_FCSR   = 12'h003;
  localparam int unsigned              FFLAGS_W   = 5;
  localparam int unsigned              FRM_W      = 3;
  localparam int unsigned              FLAG_NX    = 0;

  // --------------------------------------------------
  // Single-precision format
  // --------------------------------------------------
  localparam int unsigned         EXP_W        = 8;
  localparam int unsigned         MANT_W       = 23;
  localparam logic [EXP_W-1:0]    EXP_BIAS_TOP = 8'd158;
  localparam int unsigned         SHIFT_CNT_W  = 5;

  typedef enum logic [2:0] {
    OP_SGNJ,
    OP_SGNJN,
    OP_SGNJX,
    OP_MV_X_W,
    OP_MV_W_X,
    OP_CVT_S_W,
    OP_CSRRW,
    OP_NONE
  } fpu_op_e;

  typedef enum logic [1:0] {
    IDLE,
    CONVERT,
    WAIT_COMMIT,
    RESULT
  } ctrl_state_e;

  typedef struct packed {
    fpu_op_e                        op;
    logic [xif_pkg::REG_ADDR_W-1:0] rd;
    logic [xif_pkg::REG_ADDR_W-1:0] rs1;
    logic [xif_pkg::REG_ADDR_W-1:0] rs2;
    logic [CSR_ADDR_W-1:0]          csr_addr;
  } decoded_t;

endpackage

`default_nettype wire

/* source/fpu_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module fpu_decoder (
  input  logic [xif_pkg::XLEN-1:0] instr_i,
  output fpu_pkg::decoded_t        dec_o,
  output logic                     accept_o,
  output logic                     writeback_o
);

  fpu_pkg::rtype_t                      instr;
  logic [fpu_pkg::CSR_ADDR_W-1:0]       csr_addr;
  logic                                 csr_hit;

  assign instr    = instr_i;
  assign csr_addr = {instr.funct7, instr.rs2};

  // Only the three FP CSRs are claimed
  assign csr_hit = (instr.funct3 == fpu_pkg::F3_CSRRW) &&
                   ((csr_addr == fpu_pkg::CSR_FFLAGS) ||
                    (csr_addr == fpu_pkg::CSR_FRM) ||
                    (csr_addr == fpu_pkg::CSR_FCSR));

  always_comb begin
    dec_o.op       = fpu_pkg::OP_NONE;
    dec_o.rd       = instr.rd;
    dec_o.rs1      = instr.rs1;
    dec_o.rs2      = instr.rs2;
    dec_o.csr_addr = '0;
    case (instr.opcode)
      fpu_pkg::OPC_OP_FP: begin
        case (instr.funct7)
          fpu_pkg::F7_SGNJ: begin
            case (instr.funct3)
              fpu_pkg::F3_SGNJ:  dec_o.op = fpu_pkg::OP_SGNJ;
              fpu_pkg::F3_SGNJN: dec_o.op = fpu_pkg::OP_SGNJN;
              fpu_pkg::F3_SGNJX: dec_o.op = fpu_pkg::OP_SGNJX;
              default: ;
            endcase
          end
          fpu_pkg::F7_MV_X_W: begin
            if (instr.funct3 == fpu_pkg::F3_MV && instr.rs2 == '0) begin
              dec_o.op = fpu_pkg::OP_MV_X_W;
            end
          end
          fpu_pkg::F7_MV_W_X: begin
            if (instr.funct3 == fpu_pkg::F3_MV && instr.rs2 == '0) begin
              dec_o.op = fpu_pkg::OP_MV_W_X;
            end
          end
          // rs2 selects the signed word source, rm is ignored
          fpu_pkg::F7_CVT_S_W: begin
            if (instr.rs2 == '0) begin
              dec_o.op = fpu_pkg::OP_CVT_S_W;
            end
          end
          default: ;
        endcase
      end
      fpu_pkg::OPC_SYSTEM: begin
        if (csr_hit) begin
          dec_o.op       = fpu_pkg::OP_CSRRW;
          dec_o.csr_addr = csr_addr;
        end
      end
      default: ;
    endcase
  end

  assign accept_o    = (dec_o.op != fpu_pkg::OP_NONE);
  assign writeback_o = accept_o;

endmodule

`default_nettype wire

/* source/fpu_controller.sv */
`timescale 1ns/1ns
`default_nettype none

module fpu_controller (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        issue_valid_i,
  input  logic                        accept_i,
  input  logic [xif_pkg::ID_W-1:0]    issue_id_i,
  input  fpu_pkg::fpu_op_e            op_i,
  input  logic                        msb_set_i,
  input  logic                        commit_valid_i,
  input  xif_pkg::commit_t            commit_i,
  input  logic                        result_ready_i,
  output logic                        issue_ready_o,
  output logic                        capture_o,
  output logic                        shift_o,
  output logic                        result_valid_o,
  output logic                        commit_we_o,
  output fpu_pkg::ctrl_state_e        state_o,
  output logic [xif_pkg::ID_W-1:0]    result_id_o,
  output logic                        int_we_o,
  output logic                        fp_we_o
);

  fpu_pkg::ctrl_state_e            state_q;
  fpu_pkg::ctrl_state_e            state_d;
  fpu_pkg::fpu_op_e                op_q;
  logic [xif_pkg::ID_W-1:0]        id_q;
  logic                            committed_q;
  logic                            killed_q;
  logic                            commit_hit;
  logic                            commit_seen;
  logic                            kill_seen;

  // --------------------------------------------------
  // Commit tracking
  // --------------------------------------------------

  // First matching commit after issue wins
  assign commit_hit  = commit_valid_i && (commit_i.id == id_q) && !committed_q &&
                       (state_q != fpu_pkg::IDLE);
  assign commit_seen = committed_q || commit_hit;
  assign kill_seen   = committed_q ? killed_q : commit_i.kill;

  // --------------------------------------------------
  // Next state
  // --------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      fpu_pkg::IDLE: begin
        if (capture_o) begin
          // Already normalised magnitudes skip CONVERT
          if (op_i == fpu_pkg::OP_CVT_S_W && !msb_set_i) begin
            state_d = fpu_pkg::CONVERT;
          end else begin
            state_d = fpu_pkg::WAIT_COMMIT;
          end
        end
      end
      fpu_pkg::CONVERT: begin
        if (msb_set_i) begin
          state_d = fpu_pkg::WAIT_COMMIT;
        end
      end
      fpu_pkg::WAIT_COMMIT: begin
        if (commit_seen) begin
          state_d = kill_seen ? fpu_pkg::IDLE : fpu_pkg::RESULT;
        end
      end
      fpu_pkg::RESULT: begin
        if (result_ready_i) begin
          state_d = fpu_pkg::IDLE;
        end
      end
      default: state_d = fpu_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= fpu_pkg::IDLE;
      op_q        <= fpu_pkg::OP_NONE;
      committed_q <= 1'b0;
      killed_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      if (capture_o) begin
        op_q        <= op_i;
        committed_q <= 1'b0;
        killed_q    <= 1'b0;
      end else if (commit_hit) begin
        committed_q <= 1'b1;
        killed_q    <= commit_i.kill;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture_o) begin
      id_q <= issue_id_i;
    end
  end

  // --------------------------------------------------
  // Outputs
  // --------------------------------------------------
  assign issue_ready_o  = (state_q == fpu_pkg::IDLE);
  assign capture_o      = issue_ready_o && issue_valid_i && accept_i;
  assign shift_o        = (state_q == fpu_pkg::CONVERT);
  assign result_valid_o = (state_q == fpu_pkg::RESULT);
  assign commit_we_o    = result_valid_o && result_ready_i;
  assign state_o        = state_q;
  assign result_id_o    = id_q;

  // Integer destinations go back to the core, the rest to the FP file
  assign int_we_o = (op_q == fpu_pkg::OP_MV_X_W) || (op_q == fpu_pkg::OP_CSRRW);
  assign fp_we_o  = commit_we_o && !int_we_o;

endmodule

`default_nettype wire

/* source/norm_counter.sv */
`timescale 1ns/1ns
`default_nettype none

module norm_counter (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       load_i,
  input  logic                       step_i,
  output logic [fpu_pkg::EXP_W-1:0]  exponent_o
);

  logic [fpu_pkg::SHIFT_CNT_W-1:0] count_q;

  // Number of left shifts applied to the magnitude so far
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      count_q <= '0;
    end else if (load_i) begin
      count_q <= '0;
    end else if (step_i) begin
      count_q <= count_q + 1'b1;
    end
  end

  // Each shift lowers the exponent by one
  assign exponent_o = fpu_pkg::EXP_BIAS_TOP -
                      {{(fpu_pkg::EXP_W - fpu_pkg::SHIFT_CNT_W){1'b0}}, count_q};

endmodule

`default_nettype wire

/* source/fpu_exec.sv */
`timescale 1ns/1ns
`default_nettype none

module fpu_exec (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       capture_i,
  input  logic                       shift_i,
  input  fpu_pkg::decoded_t          dec_i,
  input  logic [xif_pkg::XLEN-1:0]   int_operand_i,
  input  logic [xif_pkg::XLEN-1:0]   fs1_i,
  input  logic [xif_pkg::XLEN-1:0]   fs2_i,
  input  logic [fpu_pkg::EXP_W-1:0]  exponent_i,
  input  logic [xif_pkg::XLEN-1:0]   csr_rdata_i,
  output logic                       msb_set_o,
  output logic [xif_pkg::XLEN-1:0]   result_data_o,
  output logic                       nx_o,
  output fpu_pkg::decoded_t          dec_o,
  output logic [xif_pkg::XLEN-1:0]   csr_wdata_o
);

  fpu_pkg::decoded_t               dec_q;
  logic [xif_pkg::XLEN-1:0]        int_q;
  logic [xif_pkg::XLEN-1:0]        fs1_q;
  logic [xif_pkg::XLEN-1:0]        fs2_q;
  logic [xif_pkg::XLEN-1:0]        mag_q;
  logic [xif_pkg::XLEN-1:0]        mag_d;
  logic                            sign_q;
  logic                            inj_sign;
  logic [xif_pkg::XLEN-1:0]        cvt_result;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dec_q <= '{op: fpu_pkg::OP_NONE, default: '0};
    end else if (capture_i) begin
      dec_q <= dec_i;
    end
  end

  // --------------------------------------------------
  // Operand capture and normalising shift register
  // --------------------------------------------------
  always_comb begin
    mag_d = mag_q;
    if (capture_i) begin
      mag_d = int_operand_i[xif_pkg::XLEN-1] ? -int_operand_i : int_operand_i;
    end else if (shift_i) begin
      mag_d = mag_q << 1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture_i) begin
      int_q  <= int_operand_i;
      fs1_q  <= fs1_i;
      fs2_q  <= fs2_i;
      sign_q <= int_operand_i[xif_pkg::XLEN-1];
    end
    mag_q <= mag_d;
  end

  // Looks one step ahead so CONVERT ends on the last shift; zero needs none
  assign msb_set_o = mag_d[xif_pkg::XLEN-1] || (mag_d == '0);

  // --------------------------------------------------
  // Result forming
  // --------------------------------------------------
  always_comb begin
    case (dec_q.op)
      fpu_pkg::OP_SGNJN: inj_sign = !fs2_q[xif_pkg::XLEN-1];
      fpu_pkg::OP_SGNJX: inj_sign = fs1_q[xif_pkg::XLEN-1] ^ fs2_q[xif_pkg::XLEN-1];
      default:           inj_sign = fs2_q[xif_pkg::XLEN-1];
    endcase
  end

  // Hidden bit dropped, remaining bits truncated
  assign cvt_result = (mag_q == '0) ? '0 :
                      {sign_q, exponent_i, mag_q[xif_pkg::XLEN-2 -: fpu_pkg::MANT_W]};

  always_comb begin
    case (dec_q.op)
      fpu_pkg::OP_SGNJ,
      fpu_pkg::OP_SGNJN,
      fpu_pkg::OP_SGNJX:  result_data_o = {inj_sign, fs1_q[xif_pkg::XLEN-2:0]};
      fpu_pkg::OP_MV_X_W:  result_data_o = fs1_q;
      fpu_pkg::OP_MV_W_X:  result_data_o = int_q;
      fpu_pkg::OP_CVT_S_W: result_data_o = cvt_result;
      fpu_pkg::OP_CSRRW:   result_data_o = csr_rdata_i;
      default:             result_data_o = '0;
    endcase
  end

  // Any one below the kept mantissa makes the result inexact
  assign nx_o = (dec_q.op == fpu_pkg::OP_CVT_S_W) &&
                (|mag_q[xif_pkg::XLEN-2-fpu_pkg::MANT_W:0]);

  assign dec_o       = dec_q;
  assign csr_wdata_o = int_q;

endmodule

`default_nettype wire

/* source/fpu_regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module fpu_regfile (
  input  logic                             clk_i,
  input  logic                             arst_n_i,
  input  logic [xif_pkg::REG_ADDR_W-1:0]   raddr1_i,
  input  logic [xif_pkg::REG_ADDR_W-1:0]   raddr2_i,
  input  logic [xif_pkg::REG_ADDR_W-1:0]   waddr_i,
  input  logic [xif_pkg::XLEN-1:0]         wdata_i,
  input  logic                             we_i,
  output logic [xif_pkg::XLEN-1:0]         rdata1_o,
  output logic [xif_pkg::XLEN-1:0]         rdata2_o
);

  logic [xif_pkg::XLEN-1:0] regs_q [2**xif_pkg::REG_ADDR_W];

  // f0 is an ordinary register here
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < 2**xif_pkg::REG_ADDR_W; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata1_o = regs_q[raddr1_i];
  assign rdata2_o = regs_q[raddr2_i];

endmodule

`default_nettype wire

/* source/fpu_csr.sv */
`timescale 1ns/1ns
`default_nettype none

module fpu_csr (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  input  logic [fpu_pkg::CSR_ADDR_W-1:0]    addr_i,
  input  logic [xif_pkg::XLEN-1:0]          wdata_i,
  input  logic                              we_i,
  input  logic                              nx_i,
  output logic [xif_pkg::XLEN-1:0]          rdata_o
);

  logic [fpu_pkg::FFLAGS_W-1:0] fflags_q;
  logic [fpu_pkg::FRM_W-1:0]    frm_q;

  // Old value of the addressed CSR
  always_comb begin
    rdata_o = '0;
    case (addr_i)
      fpu_pkg::CSR_FFLAGS: rdata_o[fpu_pkg::FFLAGS_W-1:0] = fflags_q;
      fpu_pkg::CSR_FRM:    rdata_o[fpu_pkg::FRM_W-1:0]    = frm_q;
      fpu_pkg::CSR_FCSR: begin
        rdata_o[fpu_pkg::FFLAGS_W+fpu_pkg::FRM_W-1:0] = {frm_q, fflags_q};
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      fflags_q <= '0;
      frm_q    <= '0;
    end else if (we_i) begin
      case (addr_i)
        fpu_pkg::CSR_FFLAGS: fflags_q <= wdata_i[fpu_pkg::FFLAGS_W-1:0];
        fpu_pkg::CSR_FRM:    frm_q    <= wdata_i[fpu_pkg::FRM_W-1:0];
        fpu_pkg::CSR_FCSR: begin
          fflags_q <= wdata_i[fpu_pkg::FFLAGS_W-1:0];
          frm_q    <= wdata_i[fpu_pkg::FFLAGS_W +: fpu_pkg::FRM_W];
        end
        // Non-CSR commit, sticky inexact from a conversion
        default: begin
          if (nx_i) begin
            fflags_q[fpu_pkg::FLAG_NX] <= 1'b1;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/fpu_ss_top.sv */
`timescale 1ns/1ns
`default_nettype none

module fpu_ss_top (
  input  logic                  clk_i,
  input  logic                  arst_n_i,

  // Issue channel
  input  logic                  issue_valid_i,
  output logic                  issue_ready_o,
  input  xif_pkg::issue_req_t   issue_req_i,
  output xif_pkg::issue_resp_t  issue_resp_o,

  // Commit channel
  input  logic                  commit_valid_i,
  input  xif_pkg::commit_t      commit_i,

  // Result channel
  output logic                  result_valid_o,
  input  logic                  result_ready_i,
  output xif_pkg::result_t      result_o
);

  fpu_pkg::decoded_t                dec;
  fpu_pkg::decoded_t                held_dec;
  logic                             capture;
  logic                             shift;
  logic                             msb_set;
  logic                             commit_we;
  logic                             fp_we;
  logic                             nx;
  logic [fpu_pkg::EXP_W-1:0]        exponent;
  logic [xif_pkg::XLEN-1:0]         fs1;
  logic [xif_pkg::XLEN-1:0]         fs2;
  logic [xif_pkg::XLEN-1:0]         csr_rdata;
  logic [xif_pkg::XLEN-1:0]         csr_wdata;

  assign result_o.rd = held_dec.rd;

  // --------------------------------------------------
  // Decode and control
  // --------------------------------------------------
  fpu_decoder fpu_decoder_i (
    .instr_i     (issue_req_i.instr),
    .dec_o       (dec),
    .accept_o    (issue_resp_o.accept),
    .writeback_o (issue_resp_o.writeback)
  );

  fpu_controller fpu_controller_i (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .issue_valid_i  (issue_valid_i),
    .accept_i       (issue_resp_o.accept),
    .issue_id_i     (issue_req_i.id),
    .op_i           (dec.op),
    .msb_set_i      (msb_set),
    .commit_valid_i (commit_valid_i),
    .commit_i       (commit_i),
    .result_ready_i (result_ready_i),
    .issue_ready_o  (issue_ready_o),
    .capture_o      (capture),
    .shift_o        (shift),
    .result_valid_o (result_valid_o),
    .commit_we_o    (commit_we),
    .state_o        (),
    .result_id_o    (result_o.id),
    .int_we_o       (result_o.we),
    .fp_we_o        (fp_we)
  );

  // --------------------------------------------------
  // Datapath and state
  // --------------------------------------------------
  norm_counter norm_counter_i (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .load_i     (capture),
    .step_i     (shift),
    .exponent_o (exponent)
  );

  fpu_exec fpu_exec_i (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .capture_i     (capture),
    .shift_i       (shift),
    .dec_i         (dec),
    .int_operand_i (issue_req_i.rs1),
    .fs1_i         (fs1),
    .fs2_i         (fs2),
    .exponent_i    (exponent),
    .csr_rdata_i   (csr_rdata),
    .msb_set_o     (msb_set),
    .result_data_o (result_o.data),
    .nx_o          (nx),
    .dec_o         (held_dec),
    .csr_wdata_o   (csr_wdata)
  );

  fpu_regfile fpu_regfile_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .raddr1_i (dec.rs1),
    .raddr2_i (dec.rs2),
    .waddr_i  (held_dec.rd),
    .wdata_i  (result_o.data),
    .we_i     (fp_we),
    .rdata1_o (fs1),
    .rdata2_o (fs2)
  );

  fpu_csr fpu_csr_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .addr_i   (held_dec.csr_addr),
    .wdata_i  (csr_wdata),
    .we_i     (commit_we),
    .nx_i     (nx),
    .rdata_o  (csr_rdata)
  );

endmodule

`default_nettype wire

/* bench/tb_fpu_ss.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_fpu_ss;

  localparam int    TIMEOUT = 100;
  localparam string GOLDEN  = "bench/fpu_ss_golden.txt";

  logic                  clk;
  logic                  arst_n;
  logic                  issue_valid;
  logic                  issue_ready;
  xif_pkg::issue_req_t   issue_req;
  xif_pkg::issue_resp_t  issue_resp;
  logic                  commit_valid;
  xif_pkg::commit_t      commit;
  logic                  result_valid;
  logic                  result_ready;
  xif_pkg::result_t      result;

  logic [8*32-1:0]       test_name;
  int                    test_errors;
  int                    errors;
  int                    tests;
  int                    failed;

  fpu_ss_top dut_i (
    .clk_i          (clk),
    .arst_n_i       (arst_n),
    .issue_valid_i  (issue_valid),
    .issue_ready_o  (issue_ready),
    .issue_req_i    (issue_req),
    .issue_resp_o   (issue_resp),
    .commit_valid_i (commit_valid),
    .commit_i       (commit),
    .result_valid_o (result_valid),
    .result_ready_i (result_ready),
    .result_o       (result)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // --------------------------------------------------
  // Checking and reporting
  // --------------------------------------------------
  task automatic compare(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (expected !== actual) begin
      $display("error %0s %0s: expected %h, actual %h", test_name, what, expected, actual);
      test_errors++;
    end
  endtask

  task automatic note_failure(input string msg);
    $display("%0s: %0s", test_name, msg);
    test_errors++;
  endtask

  task automatic finish_test();
    tests++;
    if (test_errors == 0) begin
      $display("%0s: ok", test_name);
    end else begin
      $display("%0s: %0d problems", test_name, test_errors);
      failed++;
      errors += test_errors;
    end
  endtask

  // --------------------------------------------------
  // Channel drivers entered on a falling edge
  // --------------------------------------------------
  task automatic issue_instr(input logic [31:0] instr, input logic [31:0] rs1,
                             input logic [3:0] id, output xif_pkg::issue_resp_t resp,
                             output logic done);
    int cycles;
    cycles          = 0;
    resp            = '0;
    issue_req.instr = instr;
    issue_req.rs1   = rs1;
    issue_req.id    = id;
    issue_valid     = 1'b1;
    while (!issue_ready && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    done = issue_ready;
    if (done) begin
      // Request still held one cycle after the transfer
      @(negedge clk);
      resp = issue_resp;
    end
    issue_valid = 1'b0;
  endtask

  task automatic send_commit(input logic [3:0] id, input logic kill);
    int delay;
    delay = $urandom % 4;
    // Kills for another id come first and must be ignored
    repeat (delay) begin
      commit_valid = 1'b1;
      commit.id    = id ^ 4'h1;
      commit.kill  = 1'b1;
      @(negedge clk);
    end
    commit_valid = 1'b1;
    commit.id    = id;
    commit.kill  = kill;
    @(negedge clk);
    commit_valid = 1'b0;
    commit       = '0;
  endtask

  task automatic take_result(input logic [31:0] exp_we, input logic [31:0] exp_data,
                             input logic [4:0] exp_rd, input logic [3:0] exp_id);
    int cycles;
    int stall;
    cycles = 0;
    while (!result_valid && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!result_valid) begin
      note_failure("result never arrived");
    end else begin
      stall = $urandom % 4;
      repeat (stall) begin
        @(negedge clk);
        compare("valid during stall", 32'd1, 32'(result_valid));
        compare("data during stall", exp_data, result.data);
      end
      result_ready = 1'b1;
      compare("we", exp_we, 32'(result.we));
      compare("data", exp_data, result.data);
      compare("rd", 32'(exp_rd), 32'(result.rd));
      compare("id", 32'(exp_id), 32'(result.id));
      @(negedge clk);
      result_ready = 1'b0;
      compare("valid after transfer", 32'd0, 32'(result_valid));
    end
  endtask

  // Killed instruction returns to idle with no result
  task automatic await_idle();
    int   cycles;
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    while (!issue_ready && cycles < TIMEOUT) begin
      seen = seen | result_valid;
      @(negedge clk);
      cycles++;
    end
    if (seen || result_valid) begin
      note_failure("a result came back for a killed instruction");
    end
    if (!issue_ready) begin
      note_failure("unit never returned to idle after the kill");
    end
  endtask

  task automatic check_quiet();
    repeat (4) begin
      @(negedge clk);
      compare("result_valid after reject", 32'd0, 32'(result_valid));
      compare("issue_ready after reject", 32'd1, 32'(issue_ready));
    end
  endtask

  task automatic run_test(input logic [31:0] instr, input logic [31:0] rs1,
                          input logic [31:0] kill, input logic [31:0] accept,
                          input logic [31:0] we, input logic [31:0] data);
    xif_pkg::issue_resp_t resp;
    logic                 done;
    logic [3:0]           id;
    test_errors = 0;
    id          = tests[3:0];
    issue_instr(instr, rs1, id, resp, done);
    if (!done) begin
      note_failure("instruction was never taken by the unit");
    end else begin
      compare("accept", accept, 32'(resp.accept));
      compare("writeback", accept, 32'(resp.writeback));
      if (!resp.accept) begin
        check_quiet();
      end else begin
        send_commit(id, kill[0]);
        if (kill[0]) begin
          await_idle();
        end else begin
          take_result(we, data, instr[11:7], id);
        end
      end
    end
    finish_test();
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    int          fd;
    int          n;
    string       line;
    logic [31:0] instr;
    logic [31:0] rs1;
    logic [31:0] kill;
    logic [31:0] accept;
    logic [31:0] we;
    logic [31:0] data;
    void'($urandom(32'heebe6a6b));
    errors       = 0;
    tests        = 0;
    failed       = 0;
    arst_n       = 1'b0;
    issue_valid  = 1'b0;
    issue_req    = '0;
    commit_valid = 1'b0;
    commit       = '0;
    result_ready = 1'b0;
    repeat (16) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);

    test_name   = "reset";
    test_errors = 0;
    compare("issue_ready", 32'd1, 32'(issue_ready));
    compare("result_valid", 32'd0, 32'(result_valid));
    finish_test();

    fd = $fopen(GOLDEN, "r");
    if (fd == 0) begin
      $display("cannot open %0s", GOLDEN);
      failed++;
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n == 0 || line.len() < 2 || line.substr(0, 0) == "#") begin
          continue;
        end
        n = $sscanf(line, "%s %h %h %h %h %h %h", test_name, instr, rs1, kill, accept,
                    we, data);
        if (n != 7) begin
          $display("golden line not understood: %0s", line);
          failed++;
          continue;
        end
        run_test(instr, rs1, kill, accept, we, data);
      end
      $fclose(fd);
    end

    $display("%0d tests, %0d failed, %0d problems", tests, failed, errors);
    if (failed == 0 && tests > 1) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* bench/fpu_ss_golden.txt */
# name instr rs1 kill accept we data, all after the name in hex
# killed or refused tests expect no result, their we and data columns stay zero
mv_w_x_f1 F00500D3 3FC00000 0 1 0 3FC00000
mv_x_w_f1 E00085D3 00000000 0 1 1 3FC00000
mv_w_x_f2 F0060153 C0200000 0 1 0 C0200000
sgnj_f3 202081D3 00000000 0 1 0 BFC00000
read_f3 E00185D3 00000000 0 1 1 BFC00000
sgnjn_f4 20209253 00000000 0 1 0 3FC00000
read_f4 E00205D3 00000000 0 1 1 3FC00000
sgnjx_f5 202122D3 00000000 0 1 0 40200000
read_f5 E00285D3 00000000 0 1 1 40200000
sgnjx_f6 20112353 00000000 0 1 0 C0200000
read_f6 E00305D3 00000000 0 1 1 C0200000
cvt_one D00503D3 00000001 0 1 0 3F800000
cvt_seven D00503D3 00000007 0 1 0 40E00000
cvt_neg_ten D00503D3 FFFFFFF6 0 1 0 C1200000
cvt_zero D00503D3 00000000 0 1 0 00000000
fflags_clean 001312F3 00000000 0 1 1 00000000
cvt_inexact D00503D3 01000001 0 1 0 4B800000
fflags_nx 001312F3 00000000 0 1 1 00000001
cvt_max D00503D3 7FFFFFFF 0 1 0 4EFFFFFF
cvt_min D00503D3 80000000 0 1 0 CF000000
read_f7 E00385D3 00000000 0 1 1 CF000000
fflags_sticky 001312F3 00000000 0 1 1 00000001
frm_set_5 002312F3 00000005 0 1 1 00000000
frm_set_3 002312F3 00000003 0 1 1 00000005
fcsr_set 003312F3 0000001F 0 1 1 00000060
fcsr_swap 003312F3 000000E5 0 1 1 0000001F
frm_read 002312F3 00000000 0 1 1 00000007
fflags_read 001312F3 00000000 0 1 1 00000005
kill_mv_f1 F00500D3 DEADBEEF 1 1 0 00000000
read_f1_after_kill E00085D3 00000000 0 1 1 3FC00000
kill_cvt D00503D3 01000001 1 1 0 00000000
fflags_after_kill 001312F3 00000000 0 1 1 00000000
reject_fadd 00208153 00000000 0 0 0 00000000
reject_mstatus 300312F3 00000000 0 0 0 00000000
reject_csrrs 001322F3 00000000 0 0 0 00000000

/* sim.f */
source/xif_pkg.sv
source/fpu_pkg.sv
source/fpu_decoder.sv
source/fpu_controller.sv
source/norm_counter.sv
source/fpu_exec.sv
source/fpu_regfile.sv
source/fpu_csr.sv
source/fpu_ss_top.sv
bench/tb_fpu_ss.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"

obj_dir/Vtb_fpu_ss: sim.f source/*.sv bench/tb_fpu_ss.sv
	verilator --binary --timescale 1ns/1ns -Wno-fatal --top-module tb_fpu_ss -f sim.f

test: obj_dir/Vtb_fpu_ss
	./obj_dir/Vtb_fpu_ss | tee sim.log
	grep -qF '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log
